//--- design/mesh_router_pkg.sv
`default_nettype none

package mesh_router_pkg;

  // tile coordinates, enough for an 8 x 8 mesh
  localparam int x_cord_width_lp = 3;
  localparam int y_cord_width_lp = 3;

  // flit payload
  localparam int data_width_lp = 16;

  // local port plus the four mesh neighbors
  localparam int dirs_lp = 5;

  // slots per input buffer
  // both ends of a link start with this many credits
  localparam int fifo_depth_lp = 4;

  // buffer pointer width, wraps at the buffer depth
  localparam int ptr_width_lp = $clog2(fifo_depth_lp);

  // holds 0 through fifo_depth_lp
  localparam int credit_width_lp = 3;

  // port index, used for every per-port array and request vector
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // single-flit packet carried on every link
  typedef struct packed {
    logic [x_cord_width_lp-1:0] dest_x;
    logic [y_cord_width_lp-1:0] dest_y;
    logic [data_width_lp-1:0]   data;
  } flit_s;

endpackage

`default_nettype wire

//--- design/mesh_route_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_route_decoder (
  input  logic [mesh_router_pkg::x_cord_width_lp-1:0] my_x_i,
  input  logic [mesh_router_pkg::y_cord_width_lp-1:0] my_y_i,
  input  logic                                        head_valid_i,
  input  logic [mesh_router_pkg::x_cord_width_lp-1:0] dest_x_i,
  input  logic [mesh_router_pkg::y_cord_width_lp-1:0] dest_y_i,
  output logic [mesh_router_pkg::dirs_lp-1:0]         req_o
);

  import mesh_router_pkg::*;

  logic               x_eq;
  logic               x_gt;
  logic               x_lt;
  logic               y_eq;
  logic               y_gt;
  logic               y_lt;
  logic [dirs_lp-1:0] req;

  // destination against own coordinates
  assign x_eq = (dest_x_i == my_x_i);
  assign y_eq = (dest_y_i == my_y_i);
  assign x_gt = (dest_x_i > my_x_i);
  assign y_gt = (dest_y_i > my_y_i);
  assign x_lt = !x_gt && !x_eq;
  assign y_lt = !y_gt && !y_eq;

  // arrived, hand to the local port
  assign req[P] = x_eq && y_eq;

  // x dimension first
  // W toward smaller x, E toward larger x
  assign req[W] = x_lt;
  assign req[E] = x_gt;

  // y dimension only once the column is reached
  // N toward smaller y, S toward larger y
  assign req[N] = x_eq && y_lt;
  assign req[S] = x_eq && y_gt;

  // exactly one bit set while a head flit is present
  assign req_o = req & {dirs_lp{head_valid_i}};

endmodule

`default_nettype wire

//--- design/mesh_input_port.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_input_port (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [mesh_router_pkg::x_cord_width_lp-1:0] my_x_i,
  input  logic [mesh_router_pkg::y_cord_width_lp-1:0] my_y_i,
  input  logic                                        flit_valid_i,
  input  mesh_router_pkg::flit_s                      flit_i,
  input  logic                                        pop_i,
  output logic [mesh_router_pkg::dirs_lp-1:0]         req_o,
  output mesh_router_pkg::flit_s                      head_flit_o,
  output logic                                        credit_o
);

  import mesh_router_pkg::*;

  flit_s                      mem_q [fifo_depth_lp];
  logic [ptr_width_lp-1:0]    wr_ptr_q;
  logic [ptr_width_lp-1:0]    rd_ptr_q;
  logic [credit_width_lp-1:0] count_q;
  logic                       head_valid;
  logic                       credit_q;

  assign head_valid  = (count_q != '0);
  assign head_flit_o = mem_q[rd_ptr_q];

  // flit storage
  // sender holds a credit per free slot, so a valid flit always fits
  always_ff @(posedge clk_i) begin
    if (flit_valid_i) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (flit_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({flit_valid_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // one credit back upstream per flit removed
  // lines up with the output valid of the same flit
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;
    end
  end

  assign credit_o = credit_q;

  // head flit routing
  mesh_route_decoder u_route_decoder (
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .head_valid_i (head_valid),
    .dest_x_i     (head_flit_o.dest_x),
    .dest_y_i     (head_flit_o.dest_y),
    .req_o        (req_o)
  );

endmodule

`default_nettype wire

//--- design/mesh_switch_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_switch_allocator (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  // req_i[i][o] set when input i asks for output o
  input  logic [mesh_router_pkg::dirs_lp-1:0][mesh_router_pkg::dirs_lp-1:0] req_i,
  input  mesh_router_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0]    head_flit_i,
  input  logic [mesh_router_pkg::dirs_lp-1:0]                      has_credit_i,
  output logic [mesh_router_pkg::dirs_lp-1:0]                      pop_o,
  output logic [mesh_router_pkg::dirs_lp-1:0]                      out_valid_o,
  output mesh_router_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0]    out_flit_o
);

  import mesh_router_pkg::*;

  // grant[o][i] set when output o goes to input i
  logic [dirs_lp-1:0][dirs_lp-1:0] grant;
  dir_e                            winner   [dirs_lp];
  // first input to consider, one past the last winner
  dir_e                            rr_ptr_q [dirs_lp];

  function automatic dir_e next_dir(input dir_e d);
    dir_e nxt;
    if (d == S) begin
      nxt = P;
    end else begin
      nxt = dir_e'(d + 3'd1);
    end
    return nxt;
  endfunction

  // round robin per output
  // scan from the far end so the input nearest the pointer ends up the winner
  always_comb begin
    int idx;
    for (int o = 0; o < dirs_lp; o++) begin
      grant[o]  = '0;
      winner[o] = P;
      for (int k = dirs_lp - 1; k >= 0; k--) begin
        idx = (int'(rr_ptr_q[o]) + k) % dirs_lp;
        if (req_i[idx][o] && has_credit_i[o]) begin
          grant[o]      = '0;
          grant[o][idx] = 1'b1;
          winner[o]     = dir_e'(idx);
        end
      end
    end
  end

  // each input asks for one output, so it is popped at most once
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < dirs_lp; o++) begin
      pop_o = pop_o | grant[o];
    end
  end

  // crossbar
  for (genvar o = 0; o < dirs_lp; o++) begin : g_xbar
    assign out_valid_o[o] = |grant[o];
    assign out_flit_o[o]  = head_flit_i[winner[o]];
  end

  // move the pointer only on a grant
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      for (int o = 0; o < dirs_lp; o++) begin
        rr_ptr_q[o] <= P;
      end
    end else begin
      for (int o = 0; o < dirs_lp; o++) begin
        if (out_valid_o[o]) begin
          rr_ptr_q[o] <= next_dir(winner[o]);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mesh_output_port.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_output_port (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   out_valid_i,
  input  mesh_router_pkg::flit_s out_flit_i,
  input  logic                   credit_i,
  output logic                   has_credit_o,
  output logic                   flit_valid_o,
  output mesh_router_pkg::flit_s flit_o
);

  import mesh_router_pkg::*;

  logic                       valid_q;
  flit_s                      flit_q;
  // free slots in the downstream input buffer
  logic [credit_width_lp-1:0] credit_cnt_q;

  // link register
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= out_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_valid_i) begin
      flit_q <= out_flit_i;
    end
  end

  // grant takes a slot, credit pulse gives one back
  // both in one cycle leave the count as is
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      credit_cnt_q <= credit_width_lp'(fifo_depth_lp);
    end else begin
      case ({out_valid_i, credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  assign has_credit_o = (credit_cnt_q != '0);

  assign flit_valid_o = valid_q;
  assign flit_o       = flit_q;

endmodule

`default_nettype wire

//--- design/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic [mesh_router_pkg::x_cord_width_lp-1:0]           my_x_i,
  input  logic [mesh_router_pkg::y_cord_width_lp-1:0]           my_y_i,
  // links from the neighbors, indexed by dir_e
  input  logic [mesh_router_pkg::dirs_lp-1:0]                   flit_valid_i,
  input  mesh_router_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0] flit_i,
  output logic [mesh_router_pkg::dirs_lp-1:0]                   credit_o,
  // links to the neighbors, indexed by dir_e
  output logic [mesh_router_pkg::dirs_lp-1:0]                   flit_valid_o,
  output mesh_router_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0] flit_o,
  input  logic [mesh_router_pkg::dirs_lp-1:0]                   credit_i
);

  import mesh_router_pkg::*;

  // req[i][o], input i toward output o
  logic [dirs_lp-1:0][dirs_lp-1:0] req;
  flit_s [dirs_lp-1:0]             head_flit;
  logic [dirs_lp-1:0]              pop;
  logic [dirs_lp-1:0]              out_valid;
  flit_s [dirs_lp-1:0]             out_flit;
  logic [dirs_lp-1:0]              has_credit;

  // input buffers with route decode
  for (genvar i = 0; i < dirs_lp; i++) begin : g_in
    mesh_input_port u_input_port (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .my_x_i       (my_x_i),
      .my_y_i       (my_y_i),
      .flit_valid_i (flit_valid_i[i]),
      .flit_i       (flit_i[i]),
      .pop_i        (pop[i]),
      .req_o        (req[i]),
      .head_flit_o  (head_flit[i]),
      .credit_o     (credit_o[i])
    );
  end

  mesh_switch_allocator u_switch_allocator (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req),
    .head_flit_i  (head_flit),
    .has_credit_i (has_credit),
    .pop_o        (pop),
    .out_valid_o  (out_valid),
    .out_flit_o   (out_flit)
  );

  // link registers and downstream credit tracking
  for (genvar o = 0; o < dirs_lp; o++) begin : g_out
    mesh_output_port u_output_port (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .out_valid_i  (out_valid[o]),
      .out_flit_i   (out_flit[o]),
      .credit_i     (credit_i[o]),
      .has_credit_o (has_credit[o]),
      .flit_valid_o (flit_valid_o[o]),
      .flit_o       (flit_o[o])
    );
  end

endmodule

`default_nettype wire

//--- tb/mesh_router_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router_sva #(
  // level_i counts used slots rather than free ones
  parameter bit level_is_used_p = 1'b0,
  // only input ports carry a request vector
  parameter bit check_req_p     = 1'b0
) (
  input logic                                        clk_i,
  input logic                                        reset_i,
  input logic [mesh_router_pkg::credit_width_lp-1:0] level_i,
  input logic                                        take_i,
  input logic [mesh_router_pkg::dirs_lp-1:0]         req_i
);

  import mesh_router_pkg::*;

  logic [credit_width_lp-1:0] free_slots;
  int unsigned                fail_cnt = 0;

  assign free_slots = level_is_used_p ? credit_width_lp'(fifo_depth_lp) - level_i : level_i;

  // never more than the buffer depth in either counting sense
  a_level_max: assert property (@(posedge clk_i) disable iff (!reset_i)
    level_i <= fifo_depth_lp)
    else begin
      $error("slot count above buffer depth");
      fail_cnt++;
    end

  // output grant needs a credit
  // input write needs a free slot
  a_take_room: assert property (@(posedge clk_i) disable iff (!reset_i)
    take_i |-> (free_slots != '0))
    else begin
      $error("slot taken while none was free");
      fail_cnt++;
    end

  if (check_req_p) begin : g_req
    a_req_onehot: assert property (@(posedge clk_i) disable iff (!reset_i)
      $onehot0(req_i))
      else begin
        $error("request vector has more than one bit set");
        fail_cnt++;
      end
  end

endmodule

bind mesh_input_port mesh_router_sva #(
  .level_is_used_p (1'b1),
  .check_req_p     (1'b1)
) u_sva (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .level_i (count_q),
  .take_i  (flit_valid_i && !pop_i),
  .req_i   (req_o)
);

bind mesh_output_port mesh_router_sva u_sva (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .level_i (credit_cnt_q),
  .take_i  (out_valid_i),
  .req_i   ('0)
);

`default_nettype wire

//--- tb/mesh_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router_tb;

  import mesh_router_pkg::*;

  // about 400 flits at a few cycles each with a wide margin
  localparam int max_cycles_lp = 20000;
  localparam int delay_tab_lp  = 1024;

  logic                                clk_i;
  logic                                reset_i;
  logic [x_cord_width_lp-1:0]          my_x_i;
  logic [y_cord_width_lp-1:0]          my_y_i;
  logic [dirs_lp-1:0]                  flit_valid_i;
  flit_s [dirs_lp-1:0]                 flit_i;
  logic [dirs_lp-1:0]                  credit_o;
  logic [dirs_lp-1:0]                  flit_valid_o;
  flit_s [dirs_lp-1:0]                 flit_o;
  logic [dirs_lp-1:0]                  credit_i;

  // neighbor models and scoreboard
  flit_s              tx_q [dirs_lp][$];
  // indexed by source * dirs_lp + output
  // source field is 3 bits
  flit_s              exp_q [8*dirs_lp][$];
  int                 down_pend [dirs_lp][$];
  int                 up_cred [dirs_lp];
  int                 down_used [dirs_lp];
  int                 sent_cnt [dirs_lp];
  int                 dlv_cnt [dirs_lp];
  int                 cred_cnt [dirs_lp];
  int                 held_cnt [dirs_lp];
  logic [12:0]        seq [dirs_lp];
  logic [dirs_lp-1:0] hold;
  int                 delay_tab [delay_tab_lp];
  int                 cycle;
  int                 dly_idx;

  mesh_router u_mesh_router (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .flit_valid_i (flit_valid_i),
    .flit_i       (flit_i),
    .credit_o     (credit_o),
    .flit_valid_o (flit_valid_o),
    .flit_o       (flit_o),
    .credit_i     (credit_i)
  );

  always #2 clk_i = ~clk_i;

  // W or E until the column matches and N or S after that
  // local port once both coordinates match
  function automatic dir_e ref_dir(input logic [2:0] dx, input logic [2:0] dy);
    if (dx == my_x_i && dy == my_y_i) return P;
    if (dx < my_x_i) return W;
    if (dx > my_x_i) return E;
    if (dy < my_y_i) return N;
    return S;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      stop_run("value mismatch, run stopped at the first error");
    end
  endtask

  // no U-turns
  // a flit only moves on away from where it came from
  function automatic flit_s rand_dest(input int src);
    flit_s f;
    f = '0;
    f.dest_x = 3'($urandom_range(7, 0));
    f.dest_y = 3'($urandom_range(7, 0));
    case (src)
      W: f.dest_x = 3'($urandom_range(7, my_x_i));
      E: f.dest_x = 3'($urandom_range(my_x_i, 0));
      N: begin
        f.dest_x = my_x_i;
        f.dest_y = 3'($urandom_range(7, my_y_i));
      end
      S: begin
        f.dest_x = my_x_i;
        f.dest_y = 3'($urandom_range(my_y_i, 0));
      end
      default: ;
    endcase
    return f;
  endfunction

  // payload holds source port and sequence number
  task automatic queue_flit(input int src, input flit_s f);
    f.data = {3'(src), seq[src]};
    seq[src] = seq[src] + 1'b1;
    tx_q[src].push_back(f);
  endtask

  function automatic bit idle();
    bit quiet;
    quiet = 1'b1;
    for (int d = 0; d < dirs_lp; d++) begin
      if (tx_q[d].size() != 0 || down_pend[d].size() != 0 || down_used[d] != 0 ||
          up_cred[d] != fifo_depth_lp) quiet = 1'b0;
    end
    for (int i = 0; i < 8*dirs_lp; i++) begin
      if (exp_q[i].size() != 0) quiet = 1'b0;
    end
    return quiet;
  endfunction

  task automatic wait_drain();
    while (!idle()) @(negedge clk_i);
  endtask

  function automatic int sva_fail_count();
    return u_mesh_router.g_in[0].u_input_port.u_sva.fail_cnt
         + u_mesh_router.g_in[1].u_input_port.u_sva.fail_cnt
         + u_mesh_router.g_in[2].u_input_port.u_sva.fail_cnt
         + u_mesh_router.g_in[3].u_input_port.u_sva.fail_cnt
         + u_mesh_router.g_in[4].u_input_port.u_sva.fail_cnt
         + u_mesh_router.g_out[0].u_output_port.u_sva.fail_cnt
         + u_mesh_router.g_out[1].u_output_port.u_sva.fail_cnt
         + u_mesh_router.g_out[2].u_output_port.u_sva.fail_cnt
         + u_mesh_router.g_out[3].u_output_port.u_sva.fail_cnt
         + u_mesh_router.g_out[4].u_output_port.u_sva.fail_cnt;
  endfunction

  // sample at the edge and drive 1 ns later
  always @(posedge clk_i) begin : link_models
    flit_s got;
    int    idx;
    cycle = cycle + 1;
    if (cycle >= max_cycles_lp) begin
      stop_run("timeout, traffic did not drain before the cycle limit");
    end else if (sva_fail_count() != 0) begin
      stop_run("a concurrent assertion failed");
    end else begin
      if (reset_i) begin
        // downstream neighbors and scoreboard
        for (int o = 0; o < dirs_lp; o++) begin
          if (flit_valid_o[o]) begin
            got = flit_o[o];
            idx = int'(got.data[15:13]) * dirs_lp + o;
            down_used[o]++;
            if (hold[o]) held_cnt[o]++;
            down_pend[o].push_back(cycle + delay_tab[dly_idx % delay_tab_lp]);
            dly_idx++;
            check("flit_o port", o, ref_dir(got.dest_x, got.dest_y));
            if (down_used[o] > fifo_depth_lp) begin
              stop_run("router sent more flits than the downstream buffer holds");
            end else if (exp_q[idx].size() == 0) begin
              stop_run("a flit left the router that was never sent on that route");
            end else begin
              check("flit_o", got, exp_q[idx].pop_front());
              dlv_cnt[got.data[15:13]]++;
            end
          end
        end
        // upstream neighbors take back credits
        for (int d = 0; d < dirs_lp; d++) begin
          if (credit_o[d]) begin
            cred_cnt[d]++;
            if (up_cred[d] >= fifo_depth_lp) begin
              stop_run("credit_o pulsed with no flit outstanding on that port");
            end else begin
              up_cred[d]++;
            end
          end
        end
      end
      #1;
      for (int d = 0; d < dirs_lp; d++) begin
        flit_valid_i[d] = 1'b0;
        if (tx_q[d].size() > 0 && up_cred[d] > 0) begin
          flit_i[d]       = tx_q[d].pop_front();
          flit_valid_i[d] = 1'b1;
          up_cred[d]--;
          sent_cnt[d]++;
          idx = d * dirs_lp + int'(ref_dir(flit_i[d].dest_x, flit_i[d].dest_y));
          exp_q[idx].push_back(flit_i[d]);
        end
      end
      for (int o = 0; o < dirs_lp; o++) begin
        credit_i[o] = 1'b0;
        if (!hold[o] && down_pend[o].size() > 0 && down_pend[o][0] <= cycle) begin
          void'(down_pend[o].pop_front());
          credit_i[o] = 1'b1;
          down_used[o]--;
        end
      end
    end
  end

  initial begin
    flit_s f;
    void'($urandom(32'he15beac4));
    clk_i        = 1'b0;
    reset_i      = 1'b0;
    my_x_i       = 3'd3;
    my_y_i       = 3'd4;
    flit_valid_i = '0;
    flit_i       = '0;
    credit_i     = '0;
    hold         = '0;
    cycle        = 0;
    dly_idx      = 0;
    for (int d = 0; d < dirs_lp; d++) begin
      up_cred[d]   = fifo_depth_lp;
      down_used[d] = 0;
      sent_cnt[d]  = 0;
      dlv_cnt[d]   = 0;
      cred_cnt[d]  = 0;
      held_cnt[d]  = 0;
      seq[d]       = '0;
    end
    for (int i = 0; i < delay_tab_lp; i++) delay_tab[i] = $urandom_range(3, 0);

    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b1;
    check("flit_valid_o after reset", flit_valid_o, 0);
    check("credit_o after reset", credit_o, 0);

    // burst of 4 into W goes out back to back on the reset credits
    @(negedge clk_i);
    for (int n = 0; n < fifo_depth_lp; n++) queue_flit(W, rand_dest(W));
    // first flit after two cycles and one more in each cycle after it
    repeat (fifo_depth_lp + 3) @(negedge clk_i);
    check("flit_valid_o pulses for W burst", dlv_cnt[W], fifo_depth_lp);
    check("credit_o[W] pulses for W burst", cred_cnt[W], fifo_depth_lp);
    wait_drain();

    // E withholds credits so only its reset credits can be used
    hold[E] = 1'b1;
    for (int n = 0; n < 12; n++) begin
      f = rand_dest(P);
      f.dest_x = 3'($urandom_range(7, my_x_i + 1));
      queue_flit(P, f);
    end
    repeat (40) @(negedge clk_i);
    check("flit_valid_o[E] count while credits held", held_cnt[E], fifo_depth_lp);
    hold[E] = 1'b0;
    wait_drain();

    // W, E, N and S all aim at the local port
    f = '0;
    f.dest_x = my_x_i;
    f.dest_y = my_y_i;
    for (int n = 0; n < 20; n++) begin
      for (int d = W; d <= S; d++) queue_flit(d, f);
    end
    wait_drain();

    // mixed traffic on all inputs
    for (int n = 0; n < 300; n++) begin
      idx_src: begin
        int src;
        src = $urandom_range(dirs_lp - 1, 0);
        queue_flit(src, rand_dest(src));
      end
    end
    wait_drain();

    for (int d = 0; d < dirs_lp; d++) begin
      check("credit_o pulse count", cred_cnt[d], sent_cnt[d]);
      check("delivered flit count", dlv_cnt[d], sent_cnt[d]);
    end
    for (int i = 0; i < 8*dirs_lp; i++) check("undelivered flits", exp_q[i].size(), 0);

    if (sva_fail_count() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_run("concurrent assertions reported failures");
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
design/mesh_router_pkg.sv
design/mesh_route_decoder.sv
design/mesh_input_port.sv
design/mesh_switch_allocator.sv
design/mesh_output_port.sv
design/mesh_router.sv
tb/mesh_router_sva.sv
tb/mesh_router_tb.sv

//--- Bender.yml
package:
  name: mesh_router

sources:
  # RTL, also pulled in for simulation
  - target: any(rtl, test)
    files:
      - design/mesh_router_pkg.sv
      - design/mesh_route_decoder.sv
      - design/mesh_input_port.sv
      - design/mesh_switch_allocator.sv
      - design/mesh_output_port.sv
      - design/mesh_router.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/mesh_router_sva.sv
      - tb/mesh_router_tb.sv
